// File: compile.f
logic/isa_pkg.sv
logic/exec_pkg.sv
logic/exec_if.sv
logic/maindec.sv
logic/aludec.sv
logic/decode_stage.sv
logic/alu.sv
logic/hilo_unit.sv
logic/exec_core.sv
verif/exec_core_sva.sv
verif/exec_core_tb.sv

// File: Makefile
TOP = exec_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: verif/exec_core_tb.sv
module exec_core_tb
	import isa_pkg::*;
	import exec_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_INSTR = 2000;
	localparam int TIMEOUT_CYCLES = 3 * N_INSTR;

	typedef enum int {
		K_ADD, K_ADDU, K_SUB, K_SUBU, K_AND, K_OR, K_XOR, K_NOR, K_SLT, K_SLTU,
		K_SLL, K_SRL, K_SRA, K_SLLV, K_SRLV, K_SRAV, K_ROTR, K_ROTRV,
		K_MOVN, K_MOVZ, K_MFHI, K_MFLO, K_MTHI, K_MTLO, K_MULT, K_MULTU, K_DIV, K_DIVU,
		K_TEQ, K_TGE, K_TGEU, K_TLT, K_TLTU, K_TNE,
		K_ADDI, K_ADDIU, K_SLTI, K_SLTIU, K_ANDI, K_ORI, K_XORI, K_LUI,
		K_TEQI, K_TGEI, K_TGEIU, K_TLTI, K_TLTIU, K_TNEI,
		K_MADD, K_MADDU, K_MUL, K_MSUB, K_MSUBU, K_CLZ, K_CLO,
		K_SEB, K_SEH, K_WSBH, K_UNKNOWN, K_COUNT
	} kind_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] instr;
		word_t       result;
		logic        wr_en;
		logic        trap;
		logic        ovf;
	} pred_t;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic [31:0] instr;
	word_t       rs_val;
	word_t       rt_val;
	logic        out_valid;
	word_t       result;
	logic        wr_en;
	logic        trap;
	logic        overflow;

	integer seed = 32'h83197655;
	pred_t  expect_q[$];
	acc_t   model_acc;
	int     err_flags;
	int     err_result;
	int     cycles;
	int     sent;

	exec_core exec_core_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.instr     (instr),
		.rs_val    (rs_val),
		.rt_val    (rt_val),
		.out_valid (out_valid),
		.result    (result),
		.wr_en     (wr_en),
		.trap      (trap),
		.overflow  (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// corner values mixed into the random operands
	function automatic word_t rand_word();
		logic [31:0] r;
		r = $random(seed);
		case (r[3:0])
			4'd0:    r = 32'h0000_0000;
			4'd1:    r = 32'hffff_ffff;
			4'd2:    r = 32'h8000_0000;
			4'd3:    r = 32'h7fff_ffff;
			default: r = $random(seed);
		endcase
		return r;
	endfunction

	function automatic word_t lead_count(word_t v, logic bit_val);
		int n;
		n = 0;
		while (n < 32 && v[31 - n] == bit_val)
			n++;
		return word_t'(n);
	endfunction

	function automatic word_t rotate_right(word_t v, logic [4:0] n);
		return (v >> n) | (v << (6'd32 - {1'b0, n}));
	endfunction

	function automatic logic [31:0] encode(kind_t k, logic [31:0] fill);
		logic [25:0] f;
		logic [19:0] mid;
		f = fill[25:0];
		// rs, rt, rd and shamt fields
		mid = fill[25:6];
		case (k)
			K_ADD:   return {SPECIAL, mid, ADD};
			K_ADDU:  return {SPECIAL, mid, ADDU};
			K_SUB:   return {SPECIAL, mid, SUB};
			K_SUBU:  return {SPECIAL, mid, SUBU};
			K_AND:   return {SPECIAL, mid, AND};
			K_OR:    return {SPECIAL, mid, OR};
			K_XOR:   return {SPECIAL, mid, XOR};
			K_NOR:   return {SPECIAL, mid, NOR};
			K_SLT:   return {SPECIAL, mid, SLT};
			K_SLTU:  return {SPECIAL, mid, SLTU};
			K_SLL:   return {SPECIAL, mid, SLL};
			K_SRA:   return {SPECIAL, mid, SRA};
			K_SLLV:  return {SPECIAL, mid, SLLV};
			K_SRAV:  return {SPECIAL, mid, SRAV};
			// rs bit 0 selects rotate for SRL, shamt bit 0 for SRLV
			K_SRL:   return {SPECIAL, 5'd0, fill[20:6], SRL};
			K_ROTR:  return {SPECIAL, 5'd1, fill[20:6], SRL};
			K_SRLV:  return {SPECIAL, fill[25:11], 5'd0, SRLV};
			K_ROTRV: return {SPECIAL, fill[25:11], 5'd1, SRLV};
			K_MOVN:  return {SPECIAL, mid, MOVN};
			K_MOVZ:  return {SPECIAL, mid, MOVZ};
			K_MFHI:  return {SPECIAL, mid, MFHI};
			K_MFLO:  return {SPECIAL, mid, MFLO};
			K_MTHI:  return {SPECIAL, mid, MTHI};
			K_MTLO:  return {SPECIAL, mid, MTLO};
			K_MULT:  return {SPECIAL, mid, MULT};
			K_MULTU: return {SPECIAL, mid, MULTU};
			K_DIV:   return {SPECIAL, mid, DIV};
			K_DIVU:  return {SPECIAL, mid, DIVU};
			K_TEQ:   return {SPECIAL, mid, TEQ};
			K_TGE:   return {SPECIAL, mid, TGE};
			K_TGEU:  return {SPECIAL, mid, TGEU};
			K_TLT:   return {SPECIAL, mid, TLT};
			K_TLTU:  return {SPECIAL, mid, TLTU};
			K_TNE:   return {SPECIAL, mid, TNE};
			K_ADDI:  return {ADDI, f};
			K_ADDIU: return {ADDIU, f};
			K_SLTI:  return {SLTI, f};
			K_SLTIU: return {SLTIU, f};
			K_ANDI:  return {ANDI, f};
			K_ORI:   return {ORI, f};
			K_XORI:  return {XORI, f};
			K_LUI:   return {LUI, f};
			K_TEQI:  return {REGIMM, fill[25:21], TEQI, fill[15:0]};
			K_TGEI:  return {REGIMM, fill[25:21], TGEI, fill[15:0]};
			K_TGEIU: return {REGIMM, fill[25:21], TGEIU, fill[15:0]};
			K_TLTI:  return {REGIMM, fill[25:21], TLTI, fill[15:0]};
			K_TLTIU: return {REGIMM, fill[25:21], TLTIU, fill[15:0]};
			K_TNEI:  return {REGIMM, fill[25:21], TNEI, fill[15:0]};
			K_MADD:  return {SPECIAL2, mid, MADD};
			K_MADDU: return {SPECIAL2, mid, MADDU};
			K_MUL:   return {SPECIAL2, mid, MUL};
			K_MSUB:  return {SPECIAL2, mid, MSUB};
			K_MSUBU: return {SPECIAL2, mid, MSUBU};
			K_CLZ:   return {SPECIAL2, mid, CLZ};
			K_CLO:   return {SPECIAL2, mid, CLO};
			K_SEB:   return {SPECIAL3, fill[25:11], SEB, BSHFL};
			K_SEH:   return {SPECIAL3, fill[25:11], SEH, BSHFL};
			K_WSBH:  return {SPECIAL3, fill[25:11], WSBH, BSHFL};
			default: return {6'b110011, f};
		endcase
	endfunction

	task automatic signed_op(input word_t x, input word_t y, input logic sub, inout pred_t p);
		longint wide;
		if (sub)
			wide = longint'($signed(x)) - longint'($signed(y));
		else
			wide = longint'($signed(x)) + longint'($signed(y));
		p.result = wide[31:0];
		// outside the signed 32-bit range
		p.ovf = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
		p.wr_en = !p.ovf;
	endtask

	task automatic issue(input kind_t k);
		logic [31:0] fill;
		word_t       a;
		word_t       b;
		word_t       imm_s;
		word_t       imm_z;
		shamt_t      s;
		acc_t        prod_s;
		acc_t        prod_u;
		pred_t       p;
		fill = $random(seed);
		a = rand_word();
		b = (fill[31:29] == 3'd0) ? a : rand_word();
		imm_s = {{16{fill[15]}}, fill[15:0]};
		imm_z = {16'h0000, fill[15:0]};
		s = fill[10:6];
		// give the immediate traps an equal operand now and then
		if (k >= K_TEQI && k <= K_TNEI && fill[28])
			a = imm_s;
		prod_s = acc_t'(longint'($signed(a)) * longint'($signed(b)));
		prod_u = {32'h0, a} * {32'h0, b};
		p = '0;
		p.valid = 1'b1;
		p.instr = encode(k, fill);
		// MOVN and MOVZ pass rs through
		p.result = a;
		p.wr_en = !(k inside {K_MULT, K_MULTU, K_MADD, K_MADDU, K_MSUB, K_MSUBU,
			K_MTHI, K_MTLO, K_DIV, K_DIVU, K_UNKNOWN, K_TEQ, K_TGE, K_TGEU, K_TLT,
			K_TLTU, K_TNE, K_TEQI, K_TGEI, K_TGEIU, K_TLTI, K_TLTIU, K_TNEI});
		case (k)
			K_ADD:   signed_op(a, b, 1'b0, p);
			K_SUB:   signed_op(a, b, 1'b1, p);
			K_ADDI:  signed_op(a, imm_s, 1'b0, p);
			K_ADDU:  p.result = a + b;
			K_ADDIU: p.result = a + imm_s;
			K_SUBU:  p.result = a - b;
			K_AND:   p.result = a & b;
			K_ANDI:  p.result = a & imm_z;
			K_OR:    p.result = a | b;
			K_ORI:   p.result = a | imm_z;
			K_XOR:   p.result = a ^ b;
			K_XORI:  p.result = a ^ imm_z;
			K_NOR:   p.result = ~(a | b);
			K_SLT:   p.result = word_t'($signed(a) < $signed(b));
			K_SLTI:  p.result = word_t'($signed(a) < $signed(imm_s));
			K_SLTU:  p.result = word_t'(a < b);
			K_SLTIU: p.result = word_t'(a < imm_s);
			K_LUI:   p.result = imm_z << 16;
			K_SLL:   p.result = b << s;
			K_SRL:   p.result = b >> s;
			K_SRA:   p.result = $signed(b) >>> s;
			K_SLLV:  p.result = b << a[4:0];
			K_SRLV:  p.result = b >> a[4:0];
			K_SRAV:  p.result = $signed(b) >>> a[4:0];
			K_ROTR:  p.result = rotate_right(b, s);
			K_ROTRV: p.result = rotate_right(b, a[4:0]);
			K_CLO:   p.result = lead_count(a, 1'b1);
			K_CLZ:   p.result = lead_count(a, 1'b0);
			K_SEB:   p.result = {{24{b[7]}}, b[7:0]};
			K_SEH:   p.result = {{16{b[15]}}, b[15:0]};
			K_WSBH:  p.result = {b[23:16], b[31:24], b[7:0], b[15:8]};
			K_MUL:   p.result = prod_s[31:0];
			K_MOVN:  p.wr_en = (b != 32'h0);
			K_MOVZ:  p.wr_en = (b == 32'h0);
			K_MFHI:  p.result = model_acc[63:32];
			K_MFLO:  p.result = model_acc[31:0];
			K_MTHI:  model_acc[63:32] = a;
			K_MTLO:  model_acc[31:0] = a;
			K_MULT:  model_acc = prod_s;
			K_MULTU: model_acc = prod_u;
			K_MADD:  model_acc = model_acc + prod_s;
			K_MADDU: model_acc = model_acc + prod_u;
			K_MSUB:  model_acc = model_acc - prod_s;
			K_MSUBU: model_acc = model_acc - prod_u;
			K_TEQ:   p.trap = (a == b);
			K_TNE:   p.trap = (a != b);
			K_TGE:   p.trap = ($signed(a) >= $signed(b));
			K_TGEU:  p.trap = (a >= b);
			K_TLT:   p.trap = ($signed(a) < $signed(b));
			K_TLTU:  p.trap = (a < b);
			K_TEQI:  p.trap = (a == imm_s);
			K_TNEI:  p.trap = (a != imm_s);
			K_TGEI:  p.trap = ($signed(a) >= $signed(imm_s));
			K_TGEIU: p.trap = (a >= imm_s);
			K_TLTI:  p.trap = ($signed(a) < $signed(imm_s));
			K_TLTIU: p.trap = (a < imm_s);
			// DIV, DIVU and unknown encodings do nothing
			default: p.trap = 1'b0;
		endcase
		in_valid = 1'b1;
		instr = p.instr;
		rs_val = a;
		rt_val = b;
		expect_q.push_back(p);
	endtask

	// garbage on the inputs must not reach HI/LO
	task automatic idle();
		pred_t p;
		kind_t k;
		p = '0;
		k = kind_t'({$random(seed)} % K_COUNT);
		p.instr = encode(k, $random(seed));
		in_valid = 1'b0;
		instr = p.instr;
		rs_val = rand_word();
		rt_val = rand_word();
		expect_q.push_back(p);
	endtask

	task automatic check_oldest();
		pred_t p;
		if (expect_q.size() >= 2) begin
			p = expect_q.pop_front();
			if (out_valid !== p.valid) begin
				err_flags++;
				$display("FAILED out_valid instr %h: got %h, expected %h",
					p.instr, out_valid, p.valid);
			end
			if (wr_en !== p.wr_en) begin
				err_flags++;
				$display("FAILED wr_en instr %h: got %h, expected %h", p.instr, wr_en, p.wr_en);
			end
			if (trap !== p.trap) begin
				err_flags++;
				$display("FAILED trap instr %h: got %h, expected %h", p.instr, trap, p.trap);
			end
			if (overflow !== p.ovf) begin
				err_flags++;
				$display("FAILED overflow instr %h: got %h, expected %h",
					p.instr, overflow, p.ovf);
			end
			// result matters when written, and sits at zero when idle
			if ((p.wr_en || !p.valid) && result !== p.result) begin
				err_result++;
				$display("FAILED result instr %h: got %h, expected %h",
					p.instr, result, p.result);
			end
		end
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [31:0] gap;
		rst = 1'b1;
		in_valid = 1'b0;
		instr = 32'h0;
		rs_val = 32'h0;
		rt_val = 32'h0;
		model_acc = '0;
		err_flags = 0;
		err_result = 0;
		sent = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (sent < N_INSTR) begin
			check_oldest();
			gap = $random(seed);
			if (gap[1:0] == 2'd0) begin
				idle();
			end else if (sent == 0) begin
				// accumulator must read back empty after reset
				issue(K_MFHI);
				sent++;
			end else begin
				issue(kind_t'({$random(seed)} % K_COUNT));
				sent++;
			end
			@(negedge clk);
		end
		repeat (2) begin
			check_oldest();
			idle();
			@(negedge clk);
		end
		$display("errors: %0d flag, %0d result, %0d total over %0d instructions",
			err_flags, err_result, err_flags + err_result, sent);
		if (err_flags + err_result == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end
endmodule

// File: verif/exec_core_sva.sv
module exec_core_sva
	import exec_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input hilo_cmd_t hilo_cmd,
	input logic      out_valid,
	input logic      wr_en,
	input logic      trap,
	input logic      overflow
);
	timeunit 1ns;
	timeprecision 1ps;

	// pipeline comes out of reset empty
	idle_after_rst: assert property (@(posedge clk)
		rst |=> !out_valid && !wr_en && !trap && !overflow && hilo_cmd == HILO_NONE)
		else $error("outputs or HI/LO command active in the cycle after reset");

	trap_needs_valid: assert property (@(posedge clk) disable iff (rst)
		trap |-> out_valid)
		else $error("trap raised without out_valid");

	ovf_needs_valid: assert property (@(posedge clk) disable iff (rst)
		overflow |-> out_valid)
		else $error("overflow raised without out_valid");

	// a trapping instruction never writes back
	no_write_on_trap: assert property (@(posedge clk) disable iff (rst)
		!(wr_en && trap))
		else $error("wr_en high together with trap");
endmodule

bind alu exec_core_sva alu_sva_i (
	.clk       (clk),
	.rst       (rst),
	.hilo_cmd  (hilo_cmd),
	.out_valid (out_valid),
	.wr_en     (wr_en),
	.trap      (trap),
	.overflow  (overflow)
);

// File: logic/exec_core.sv
module exec_core
	import exec_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  logic [31:0] instr,
	input  word_t       rs_val,
	input  word_t       rt_val,
	output logic        out_valid,
	output word_t       result,
	output logic        wr_en,
	output logic        trap,
	output logic        overflow
);
	hilo_cmd_t hilo_cmd;
	acc_t      hilo_val;
	word_t     hi;
	word_t     lo;

	exec_if dx ();

	decode_stage u_decode (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.instr    (instr),
		.rs_val   (rs_val),
		.rt_val   (rt_val),
		.dx       (dx.decode)
	);

	alu u_alu (
		.clk       (clk),
		.rst       (rst),
		.dx        (dx.alu),
		.hi        (hi),
		.lo        (lo),
		.hilo_cmd  (hilo_cmd),
		.hilo_val  (hilo_val),
		.out_valid (out_valid),
		.result    (result),
		.wr_en     (wr_en),
		.trap      (trap),
		.overflow  (overflow)
	);

	hilo_unit u_hilo (
		.clk      (clk),
		.rst      (rst),
		.hilo_cmd (hilo_cmd),
		.hilo_val (hilo_val),
		.hi       (hi),
		.lo       (lo)
	);
endmodule

// File: logic/hilo_unit.sv
module hilo_unit
	import exec_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  hilo_cmd_t hilo_cmd,
	input  acc_t      hilo_val,
	output word_t     hi,
	output word_t     lo
);
	acc_t acc;

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
		end else begin
			case (hilo_cmd)
				HILO_WRITE: acc <= hilo_val;
				HILO_ADD:   acc <= acc + hilo_val;
				HILO_SUB:   acc <= acc - hilo_val;
				default:    acc <= acc;
			endcase
		end
	end

	assign hi = acc[2*XLEN-1:XLEN];
	assign lo = acc[XLEN-1:0];
endmodule

// File: logic/alu.sv
module alu
	import exec_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	exec_if.alu       dx,
	input  word_t     hi,
	input  word_t     lo,
	output hilo_cmd_t hilo_cmd,
	output acc_t      hilo_val,
	output logic      out_valid,
	output word_t     result,
	output logic      wr_en,
	output logic      trap,
	output logic      overflow
);
	word_t       a;
	word_t       b;
	shamt_t      sa;
	logic [XLEN:0] sum;
	logic [XLEN:0] diff;
	acc_t        prod_s;
	acc_t        prod_u;
	word_t       rot;
	word_t       res;
	logic        we;
	logic        trp;
	logic        ovf;
	hilo_cmd_t   cmd;

	function automatic logic [5:0] lead_zeros(word_t v);
		logic [5:0] n;
		n = 6'(XLEN);
		for (int i = 0; i < XLEN; i++) begin
			if (v[i])
				n = 6'(XLEN - 1 - i);
		end
		return n;
	endfunction

	assign a = dx.a;
	assign b = dx.b;
	assign sa = dx.uses_imm ? dx.shamt : a[4:0];
	// one extra bit to see signed overflow
	assign sum = {a[XLEN-1], a} + {b[XLEN-1], b};
	assign diff = {a[XLEN-1], a} - {b[XLEN-1], b};
	assign prod_s = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
	assign prod_u = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
	assign rot = word_t'({b, b} >> sa);

	always_comb begin
		res = '0;
		we = 1'b1;
		ovf = 1'b0;
		cmd = HILO_NONE;
		hilo_val = prod_s;
		case (dx.ctrl)
			AND_CONTROL:  res = a & b;
			OR_CONTROL:   res = a | b;
			XOR_CONTROL:  res = a ^ b;
			NOR_CONTROL:  res = ~(a | b);
			ADD_CONTROL: begin
				res = sum[XLEN-1:0];
				ovf = sum[XLEN] ^ sum[XLEN-1];
				we = ~ovf;
			end
			SUB_CONTROL: begin
				res = diff[XLEN-1:0];
				ovf = diff[XLEN] ^ diff[XLEN-1];
				we = ~ovf;
			end
			ADDU_CONTROL: res = a + b;
			SUBU_CONTROL: res = a - b;
			SLT_CONTROL:  res = word_t'($signed(a) < $signed(b));
			SLTU_CONTROL: res = word_t'(a < b);
			LUI_CONTROL:  res = b;
			SLL_CONTROL, SLLV_CONTROL:   res = b << sa;
			SRL_CONTROL, SRLV_CONTROL:   res = b >> sa;
			SRA_CONTROL, SRAV_CONTROL:   res = $signed(b) >>> sa;
			ROTR_CONTROL, ROTRV_CONTROL: res = rot;
			CLO_CONTROL:  res = word_t'(lead_zeros(~a));
			CLZ_CONTROL:  res = word_t'(lead_zeros(a));
			SEB_CONTROL:  res = {{24{b[7]}}, b[7:0]};
			SEH_CONTROL:  res = {{16{b[15]}}, b[15:0]};
			WSBH_CONTROL: res = {b[23:16], b[31:24], b[7:0], b[15:8]};
			MUL_CONTROL:  res = prod_s[XLEN-1:0];
			MOVN_CONTROL: begin
				res = a;
				we = (b != '0);
			end
			MOVZ_CONTROL: begin
				res = a;
				we = (b == '0);
			end
			MFHI_CONTROL: res = hi;
			MFLO_CONTROL: res = lo;
			// moves keep the other half as it is
			MTHI_CONTROL: begin
				we = 1'b0;
				cmd = HILO_WRITE;
				hilo_val = {a, lo};
			end
			MTLO_CONTROL: begin
				we = 1'b0;
				cmd = HILO_WRITE;
				hilo_val = {hi, a};
			end
			MULT_CONTROL: begin
				we = 1'b0;
				cmd = HILO_WRITE;
			end
			MULTU_CONTROL: begin
				we = 1'b0;
				cmd = HILO_WRITE;
				hilo_val = prod_u;
			end
			MADD_CONTROL: begin
				we = 1'b0;
				cmd = HILO_ADD;
			end
			MADDU_CONTROL: begin
				we = 1'b0;
				cmd = HILO_ADD;
				hilo_val = prod_u;
			end
			MSUB_CONTROL: begin
				we = 1'b0;
				cmd = HILO_SUB;
			end
			MSUBU_CONTROL: begin
				we = 1'b0;
				cmd = HILO_SUB;
				hilo_val = prod_u;
			end
			TEQ_CONTROL, TGE_CONTROL, TGEU_CONTROL, TLT_CONTROL, TLTU_CONTROL,
			TNE_CONTROL, TEQI_CONTROL, TGEI_CONTROL, TGEIU_CONTROL, TLTI_CONTROL,
			TLTIU_CONTROL, TNEI_CONTROL: we = 1'b0;
			default: we = 1'b0;
		endcase
	end

	// immediate traps share the compare with the register forms
	always_comb begin
		case (dx.ctrl)
			TEQ_CONTROL, TEQI_CONTROL:   trp = (a == b);
			TNE_CONTROL, TNEI_CONTROL:   trp = (a != b);
			TGE_CONTROL, TGEI_CONTROL:   trp = ($signed(a) >= $signed(b));
			TGEU_CONTROL, TGEIU_CONTROL: trp = (a >= b);
			TLT_CONTROL, TLTI_CONTROL:   trp = ($signed(a) < $signed(b));
			TLTU_CONTROL, TLTIU_CONTROL: trp = (a < b);
			default: trp = 1'b0;
		endcase
	end

	assign hilo_cmd = dx.valid ? cmd : HILO_NONE;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			result <= '0;
			wr_en <= 1'b0;
			trap <= 1'b0;
			overflow <= 1'b0;
		end else begin
			out_valid <= dx.valid;
			result <= dx.valid ? res : '0;
			wr_en <= dx.valid & we;
			trap <= dx.valid & trp;
			overflow <= dx.valid & ovf;
		end
	end
endmodule

// File: logic/decode_stage.sv
module decode_stage
	import isa_pkg::*;
	import exec_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  logic [31:0] instr,
	input  word_t       rs_val,
	input  word_t       rt_val,
	exec_if.decode      dx
);
	opcode_t   opcode;
	funct_t    funct;
	subcode_t  rs_code;
	subcode_t  rt_code;
	subcode_t  shamt_code;
	logic [15:0] imm;
	aluop_t    aluop;
	imm_kind_t imm_kind;
	alu_ctrl_t ctrl;
	word_t     b_next;
	logic      field_shift;

	assign opcode = instr[31:26];
	assign rs_code = instr[25:21];
	assign rt_code = instr[20:16];
	assign shamt_code = instr[10:6];
	assign funct = instr[5:0];
	assign imm = instr[15:0];

	maindec u_maindec (
		.opcode     (opcode),
		.funct      (funct),
		.rs_code    (rs_code),
		.rt_code    (rt_code),
		.shamt_code (shamt_code),
		.aluop      (aluop),
		.imm_kind   (imm_kind)
	);

	aludec u_aludec (
		.funct      (funct),
		.aluop      (aluop),
		.alucontrol (ctrl)
	);

	always_comb begin
		case (imm_kind)
			IMM_SIGN: b_next = {{16{imm[15]}}, imm};
			// LUI already lands in the upper half
			IMM_ZERO: b_next = (aluop == LUI_OP) ? {imm, 16'h0000} : {16'h0000, imm};
			default:  b_next = rt_val;
		endcase
	end

	// shift amount taken from the instruction, not from rs
	assign field_shift = (ctrl == SLL_CONTROL) || (ctrl == SRL_CONTROL) ||
		(ctrl == SRA_CONTROL) || (ctrl == ROTR_CONTROL);

	always_ff @(posedge clk) begin
		if (rst)
			dx.valid <= 1'b0;
		else
			dx.valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		dx.ctrl <= ctrl;
		dx.a <= rs_val;
		dx.b <= b_next;
		dx.shamt <= shamt_code;
		dx.uses_imm <= (imm_kind != IMM_NONE) || field_shift;
	end
endmodule

// File: logic/aludec.sv
module aludec
	import isa_pkg::*;
	import exec_pkg::*;
(
	input  funct_t    funct,
	input  aluop_t    aluop,
	output alu_ctrl_t alucontrol
);
	always_comb begin
		case (aluop)
			R_TYPE_OP: begin
				case (funct)
					// logic and arithmetic
					AND:     alucontrol = AND_CONTROL;
					OR:      alucontrol = OR_CONTROL;
					XOR:     alucontrol = XOR_CONTROL;
					NOR:     alucontrol = NOR_CONTROL;
					ADD:     alucontrol = ADD_CONTROL;
					SUB:     alucontrol = SUB_CONTROL;
					ADDU:    alucontrol = ADDU_CONTROL;
					SUBU:    alucontrol = SUBU_CONTROL;
					SLT:     alucontrol = SLT_CONTROL;
					SLTU:    alucontrol = SLTU_CONTROL;
					MULT:    alucontrol = MULT_CONTROL;
					MULTU:   alucontrol = MULTU_CONTROL;
					// shifts
					SLL:     alucontrol = SLL_CONTROL;
					SRL:     alucontrol = SRL_CONTROL;
					SRA:     alucontrol = SRA_CONTROL;
					SLLV:    alucontrol = SLLV_CONTROL;
					SRLV:    alucontrol = SRLV_CONTROL;
					SRAV:    alucontrol = SRAV_CONTROL;
					// hi/lo moves
					MTHI:    alucontrol = MTHI_CONTROL;
					MTLO:    alucontrol = MTLO_CONTROL;
					MFHI:    alucontrol = MFHI_CONTROL;
					MFLO:    alucontrol = MFLO_CONTROL;
					MOVN:    alucontrol = MOVN_CONTROL;
					MOVZ:    alucontrol = MOVZ_CONTROL;
					// register traps
					TEQ:     alucontrol = TEQ_CONTROL;
					TGE:     alucontrol = TGE_CONTROL;
					TGEU:    alucontrol = TGEU_CONTROL;
					TLT:     alucontrol = TLT_CONTROL;
					TLTU:    alucontrol = TLTU_CONTROL;
					TNE:     alucontrol = TNE_CONTROL;
					// no divider, DIV and DIVU fall through
					default: alucontrol = NOP_CONTROL;
				endcase
			end
			ADDI_OP:  alucontrol = ADD_CONTROL;
			ADDIU_OP: alucontrol = ADDU_CONTROL;
			SLTI_OP:  alucontrol = SLT_CONTROL;
			SLTIU_OP: alucontrol = SLTU_CONTROL;
			ANDI_OP:  alucontrol = AND_CONTROL;
			ORI_OP:   alucontrol = OR_CONTROL;
			XORI_OP:  alucontrol = XOR_CONTROL;
			LUI_OP:   alucontrol = LUI_CONTROL;
			CLO_OP:   alucontrol = CLO_CONTROL;
			CLZ_OP:   alucontrol = CLZ_CONTROL;
			SEB_OP:   alucontrol = SEB_CONTROL;
			SEH_OP:   alucontrol = SEH_CONTROL;
			WSBH_OP:  alucontrol = WSBH_CONTROL;
			ROTR_OP:  alucontrol = ROTR_CONTROL;
			ROTRV_OP: alucontrol = ROTRV_CONTROL;
			MADD_OP:  alucontrol = MADD_CONTROL;
			MADDU_OP: alucontrol = MADDU_CONTROL;
			MSUB_OP:  alucontrol = MSUB_CONTROL;
			MSUBU_OP: alucontrol = MSUBU_CONTROL;
			MUL_OP:   alucontrol = MUL_CONTROL;
			TEQI_OP:  alucontrol = TEQI_CONTROL;
			TGEI_OP:  alucontrol = TGEI_CONTROL;
			TGEIU_OP: alucontrol = TGEIU_CONTROL;
			TLTI_OP:  alucontrol = TLTI_CONTROL;
			TLTIU_OP: alucontrol = TLTIU_CONTROL;
			TNEI_OP:  alucontrol = TNEI_CONTROL;
			default:  alucontrol = NOP_CONTROL;
		endcase
	end
endmodule

// File: logic/maindec.sv
module maindec
	import isa_pkg::*;
(
	input  opcode_t    opcode,
	input  funct_t     funct,
	input  subcode_t   rs_code,
	input  subcode_t   rt_code,
	input  subcode_t   shamt_code,
	output aluop_t     aluop,
	output imm_kind_t  imm_kind
);
	always_comb begin
		aluop = NONE_OP;
		imm_kind = IMM_NONE;
		case (opcode)
			SPECIAL: begin
				// rotates hide inside the logical right shifts
				if (funct == SRL && rs_code[0])
					aluop = ROTR_OP;
				else if (funct == SRLV && shamt_code[0])
					aluop = ROTRV_OP;
				else
					aluop = R_TYPE_OP;
			end
			SPECIAL2: begin
				case (funct)
					MADD:    aluop = MADD_OP;
					MADDU:   aluop = MADDU_OP;
					MUL:     aluop = MUL_OP;
					MSUB:    aluop = MSUB_OP;
					MSUBU:   aluop = MSUBU_OP;
					CLZ:     aluop = CLZ_OP;
					CLO:     aluop = CLO_OP;
					default: aluop = NONE_OP;
				endcase
			end
			SPECIAL3: begin
				if (funct == BSHFL) begin
					case (shamt_code)
						SEB:     aluop = SEB_OP;
						SEH:     aluop = SEH_OP;
						WSBH:    aluop = WSBH_OP;
						default: aluop = NONE_OP;
					endcase
				end
			end
			REGIMM: begin
				imm_kind = IMM_SIGN;
				case (rt_code)
					TEQI:    aluop = TEQI_OP;
					TGEI:    aluop = TGEI_OP;
					TGEIU:   aluop = TGEIU_OP;
					TLTI:    aluop = TLTI_OP;
					TLTIU:   aluop = TLTIU_OP;
					TNEI:    aluop = TNEI_OP;
					default: aluop = NONE_OP;
				endcase
			end
			ADDI: begin
				aluop = ADDI_OP;
				imm_kind = IMM_SIGN;
			end
			ADDIU: begin
				aluop = ADDIU_OP;
				imm_kind = IMM_SIGN;
			end
			SLTI: begin
				aluop = SLTI_OP;
				imm_kind = IMM_SIGN;
			end
			SLTIU: begin
				aluop = SLTIU_OP;
				imm_kind = IMM_SIGN;
			end
			ANDI: begin
				aluop = ANDI_OP;
				imm_kind = IMM_ZERO;
			end
			ORI: begin
				aluop = ORI_OP;
				imm_kind = IMM_ZERO;
			end
			XORI: begin
				aluop = XORI_OP;
				imm_kind = IMM_ZERO;
			end
			LUI: begin
				aluop = LUI_OP;
				imm_kind = IMM_ZERO;
			end
			default: aluop = NONE_OP;
		endcase
	end
endmodule

// File: logic/exec_if.sv
interface exec_if
	import exec_pkg::*;
();
	logic      valid;
	alu_ctrl_t ctrl;
	word_t     a;
	// extended immediate already folded in for I-type
	word_t     b;
	shamt_t    shamt;
	logic      uses_imm;

	modport decode (
		output valid,
		output ctrl,
		output a,
		output b,
		output shamt,
		output uses_imm
	);

	modport alu (
		input valid,
		input ctrl,
		input a,
		input b,
		input shamt,
		input uses_imm
	);
endinterface

// File: logic/exec_pkg.sv
package exec_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [2*XLEN-1:0] acc_t;
	typedef logic [7:0]        alu_ctrl_t;
	typedef logic [4:0]        shamt_t;
	typedef logic [1:0]        hilo_cmd_t;

	localparam hilo_cmd_t HILO_NONE  = 2'd0;
	localparam hilo_cmd_t HILO_WRITE = 2'd1;
	localparam hilo_cmd_t HILO_ADD   = 2'd2;
	localparam hilo_cmd_t HILO_SUB   = 2'd3;

	localparam alu_ctrl_t NOP_CONTROL   = 8'd0;
	localparam alu_ctrl_t AND_CONTROL   = 8'd1;
	localparam alu_ctrl_t OR_CONTROL    = 8'd2;
	localparam alu_ctrl_t XOR_CONTROL   = 8'd3;
	localparam alu_ctrl_t NOR_CONTROL   = 8'd4;
	localparam alu_ctrl_t ADD_CONTROL   = 8'd5;
	localparam alu_ctrl_t SUB_CONTROL   = 8'd6;
	localparam alu_ctrl_t ADDU_CONTROL  = 8'd7;
	localparam alu_ctrl_t SUBU_CONTROL  = 8'd8;
	localparam alu_ctrl_t SLT_CONTROL   = 8'd9;
	localparam alu_ctrl_t SLTU_CONTROL  = 8'd10;
	localparam alu_ctrl_t LUI_CONTROL   = 8'd11;
	localparam alu_ctrl_t SLL_CONTROL   = 8'd12;
	localparam alu_ctrl_t SRL_CONTROL   = 8'd13;
	localparam alu_ctrl_t SRA_CONTROL   = 8'd14;
	localparam alu_ctrl_t SLLV_CONTROL  = 8'd15;
	localparam alu_ctrl_t SRLV_CONTROL  = 8'd16;
	localparam alu_ctrl_t SRAV_CONTROL  = 8'd17;
	localparam alu_ctrl_t ROTR_CONTROL  = 8'd18;
	localparam alu_ctrl_t ROTRV_CONTROL = 8'd19;
	localparam alu_ctrl_t CLO_CONTROL   = 8'd20;
	localparam alu_ctrl_t CLZ_CONTROL   = 8'd21;
	localparam alu_ctrl_t SEB_CONTROL   = 8'd22;
	localparam alu_ctrl_t SEH_CONTROL   = 8'd23;
	localparam alu_ctrl_t WSBH_CONTROL  = 8'd24;
	localparam alu_ctrl_t MOVN_CONTROL  = 8'd25;
	localparam alu_ctrl_t MOVZ_CONTROL  = 8'd26;
	localparam alu_ctrl_t MUL_CONTROL   = 8'd27;
	localparam alu_ctrl_t MULT_CONTROL  = 8'd28;
	localparam alu_ctrl_t MULTU_CONTROL = 8'd29;
	localparam alu_ctrl_t MADD_CONTROL  = 8'd30;
	localparam alu_ctrl_t MADDU_CONTROL = 8'd31;
	localparam alu_ctrl_t MSUB_CONTROL  = 8'd32;
	localparam alu_ctrl_t MSUBU_CONTROL = 8'd33;
	localparam alu_ctrl_t MFHI_CONTROL  = 8'd34;
	localparam alu_ctrl_t MFLO_CONTROL  = 8'd35;
	localparam alu_ctrl_t MTHI_CONTROL  = 8'd36;
	localparam alu_ctrl_t MTLO_CONTROL  = 8'd37;
	localparam alu_ctrl_t TEQ_CONTROL   = 8'd38;
	localparam alu_ctrl_t TGE_CONTROL   = 8'd39;
	localparam alu_ctrl_t TGEU_CONTROL  = 8'd40;
	localparam alu_ctrl_t TLT_CONTROL   = 8'd41;
	localparam alu_ctrl_t TLTU_CONTROL  = 8'd42;
	localparam alu_ctrl_t TNE_CONTROL   = 8'd43;
	localparam alu_ctrl_t TEQI_CONTROL  = 8'd44;
	localparam alu_ctrl_t TGEI_CONTROL  = 8'd45;
	localparam alu_ctrl_t TGEIU_CONTROL = 8'd46;
	localparam alu_ctrl_t TLTI_CONTROL  = 8'd47;
	localparam alu_ctrl_t TLTIU_CONTROL = 8'd48;
	localparam alu_ctrl_t TNEI_CONTROL  = 8'd49;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [5:0] aluop_t;
	typedef logic [4:0] subcode_t;

	typedef enum logic [1:0] {
		IMM_SIGN,
		IMM_ZERO,
		IMM_NONE
	} imm_kind_t;

	// major opcodes
	localparam opcode_t SPECIAL  = 6'b000000;
	localparam opcode_t REGIMM   = 6'b000001;
	localparam opcode_t ADDI     = 6'b001000;
	localparam opcode_t ADDIU    = 6'b001001;
	localparam opcode_t SLTI     = 6'b001010;
	localparam opcode_t SLTIU    = 6'b001011;
	localparam opcode_t ANDI     = 6'b001100;
	localparam opcode_t ORI      = 6'b001101;
	localparam opcode_t XORI     = 6'b001110;
	localparam opcode_t LUI      = 6'b001111;
	localparam opcode_t SPECIAL2 = 6'b011100;
	localparam opcode_t SPECIAL3 = 6'b011111;

	// SPECIAL functs
	localparam funct_t SLL   = 6'b000000;
	localparam funct_t SRL   = 6'b000010;
	localparam funct_t SRA   = 6'b000011;
	localparam funct_t SLLV  = 6'b000100;
	localparam funct_t SRLV  = 6'b000110;
	localparam funct_t SRAV  = 6'b000111;
	localparam funct_t MOVZ  = 6'b001010;
	localparam funct_t MOVN  = 6'b001011;
	localparam funct_t MFHI  = 6'b010000;
	localparam funct_t MTHI  = 6'b010001;
	localparam funct_t MFLO  = 6'b010010;
	localparam funct_t MTLO  = 6'b010011;
	localparam funct_t MULT  = 6'b011000;
	localparam funct_t MULTU = 6'b011001;
	localparam funct_t DIV   = 6'b011010;
	localparam funct_t DIVU  = 6'b011011;
	localparam funct_t ADD   = 6'b100000;
	localparam funct_t ADDU  = 6'b100001;
	localparam funct_t SUB   = 6'b100010;
	localparam funct_t SUBU  = 6'b100011;
	localparam funct_t AND   = 6'b100100;
	localparam funct_t OR    = 6'b100101;
	localparam funct_t XOR   = 6'b100110;
	localparam funct_t NOR   = 6'b100111;
	localparam funct_t SLT   = 6'b101010;
	localparam funct_t SLTU  = 6'b101011;
	localparam funct_t TGE   = 6'b110000;
	localparam funct_t TGEU  = 6'b110001;
	localparam funct_t TLT   = 6'b110010;
	localparam funct_t TLTU  = 6'b110011;
	localparam funct_t TEQ   = 6'b110100;
	localparam funct_t TNE   = 6'b110110;

	// SPECIAL2 functs
	localparam funct_t MADD  = 6'b000000;
	localparam funct_t MADDU = 6'b000001;
	localparam funct_t MUL   = 6'b000010;
	localparam funct_t MSUB  = 6'b000100;
	localparam funct_t MSUBU = 6'b000101;
	localparam funct_t CLZ   = 6'b100000;
	localparam funct_t CLO   = 6'b100001;

	// SPECIAL3, sub-code sits in shamt
	localparam funct_t BSHFL  = 6'b100000;
	localparam subcode_t WSBH = 5'b00010;
	localparam subcode_t SEB  = 5'b10000;
	localparam subcode_t SEH  = 5'b11000;

	// REGIMM rt codes
	localparam subcode_t TGEI  = 5'b01000;
	localparam subcode_t TGEIU = 5'b01001;
	localparam subcode_t TLTI  = 5'b01010;
	localparam subcode_t TLTIU = 5'b01011;
	localparam subcode_t TEQI  = 5'b01100;
	localparam subcode_t TNEI  = 5'b01110;

	// ALU opcode classes
	localparam aluop_t R_TYPE_OP = 6'h00;
	localparam aluop_t ADDI_OP   = 6'h01;
	localparam aluop_t ADDIU_OP  = 6'h02;
	localparam aluop_t SLTI_OP   = 6'h03;
	localparam aluop_t SLTIU_OP  = 6'h04;
	localparam aluop_t ANDI_OP   = 6'h05;
	localparam aluop_t ORI_OP    = 6'h06;
	localparam aluop_t XORI_OP   = 6'h07;
	localparam aluop_t LUI_OP    = 6'h08;
	localparam aluop_t CLO_OP    = 6'h09;
	localparam aluop_t CLZ_OP    = 6'h0a;
	localparam aluop_t SEB_OP    = 6'h0b;
	localparam aluop_t SEH_OP    = 6'h0c;
	localparam aluop_t WSBH_OP   = 6'h0d;
	localparam aluop_t ROTR_OP   = 6'h0e;
	localparam aluop_t ROTRV_OP  = 6'h0f;
	localparam aluop_t MADD_OP   = 6'h10;
	localparam aluop_t MADDU_OP  = 6'h11;
	localparam aluop_t MSUB_OP   = 6'h12;
	localparam aluop_t MSUBU_OP  = 6'h13;
	localparam aluop_t MUL_OP    = 6'h14;
	localparam aluop_t TEQI_OP   = 6'h15;
	localparam aluop_t TGEI_OP   = 6'h16;
	localparam aluop_t TGEIU_OP  = 6'h17;
	localparam aluop_t TLTI_OP   = 6'h18;
	localparam aluop_t TLTIU_OP  = 6'h19;
	localparam aluop_t TNEI_OP   = 6'h1a;
	localparam aluop_t NONE_OP   = 6'h3f;

endpackage
